// ==== riscv_consts.svh ====
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

`define RV_XLEN      32
`define RV_AW        12
`define RV_RESET_PC  32'h0000_0000

// major opcodes, instr[6:0]
`define RV_OP_OP      7'b0110011
`define RV_OP_OPIMM   7'b0010011
`define RV_OP_LUI     7'b0110111
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111
`define RV_OP_SYSTEM  7'b1110011

`define RV_EBREAK  32'h0010_0073
`define RV_NOP     32'h0000_0013  // addi x0, x0, 0

`endif

// ==== riscvPkg.sv ====
`include "riscv_consts.svh"

package riscvPkg;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluXor,
      aluSlt,
      aluSll,
      aluSrl,
      aluPassB  // lui
   } aluOpT;

   typedef enum logic [1:0] {
      wbAlu,
      wbMem,
      wbPc4
   } wbSrcT;

   typedef enum logic [1:0] {
      fwdReg,
      fwdMem,
      fwdWb
   } fwdSelT;

   typedef struct packed {
      logic               valid;
      logic [`RV_XLEN-1:0] pc;
      logic [`RV_XLEN-1:0] pcPlus4;
      logic [4:0]          rs1;
      logic [4:0]          rs2;
      logic [4:0]          rd;
      logic [`RV_XLEN-1:0] rd1;
      logic [`RV_XLEN-1:0] rd2;
      logic [`RV_XLEN-1:0] imm;
      aluOpT               aluOp;
      logic                aluSrcA;  // 1: pc
      logic                aluSrcB;  // 1: imm
      logic                memRead;
      logic                memWrite;
      wbSrcT               wbSrc;
      logic                regWrite;
      logic                isBranch;
      logic                branchNe;
      logic                isJump;
      logic                isHalt;
   } idExT;

   typedef struct packed {
      logic                valid;
      logic [`RV_XLEN-1:0] aluOut;
      logic [`RV_XLEN-1:0] storeData;
      logic [`RV_XLEN-1:0] pcPlus4;
      logic [4:0]          rd;
      logic                memRead;
      logic                memWrite;
      wbSrcT               wbSrc;
      logic                regWrite;
      logic                isHalt;
   } exMemT;

   typedef struct packed {
      logic                valid;
      logic [`RV_XLEN-1:0] aluOut;
      logic [`RV_XLEN-1:0] loadData;
      logic [`RV_XLEN-1:0] pcPlus4;
      logic [4:0]          rd;
      wbSrcT               wbSrc;
      logic                regWrite;
      logic                isHalt;
   } memWbT;

endpackage

// ==== pipeCtrl.sv ====
`include "riscv_consts.svh"

module pipeCtrl (
   input  logic [`RV_XLEN-1:0] instr,
   output logic [4:0]          rs1,
   output logic [4:0]          rs2,
   output logic [4:0]          rd,
   output logic [`RV_XLEN-1:0] imm,
   output riscvPkg::aluOpT     aluOp,
   output logic                aluSrcA,
   output logic                aluSrcB,
   output logic                memRead,
   output logic                memWrite,
   output riscvPkg::wbSrcT     wbSrc,
   output logic                regWrite,
   output logic                isBranch,
   output logic                branchNe,
   output logic                isJump,
   output logic                isHalt
);
   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic            regW;
   logic            useRs1;
   logic            useRs2;
   riscvPkg::aluOpT fnOp;

   assign opcode   = instr[6:0];
   assign funct3   = instr[14:12];
   assign rd       = instr[11:7];
   assign rs1      = useRs1 ? instr[19:15] : 5'd0;  // zeroed so no false load-use stall
   assign rs2      = useRs2 ? instr[24:20] : 5'd0;
   assign regWrite = regW && (rd != 5'd0);

   always_comb begin
      case (funct3)
         3'b000:  fnOp = (opcode == `RV_OP_OP && instr[30]) ? riscvPkg::aluSub
                                                            : riscvPkg::aluAdd;
         3'b001:  fnOp = riscvPkg::aluSll;
         3'b010:  fnOp = riscvPkg::aluSlt;
         3'b100:  fnOp = riscvPkg::aluXor;
         3'b101:  fnOp = riscvPkg::aluSrl;
         3'b110:  fnOp = riscvPkg::aluOr;
         3'b111:  fnOp = riscvPkg::aluAnd;
         default: fnOp = riscvPkg::aluAdd;
      endcase
   end

   always_comb begin
      imm      = '0;
      aluOp    = riscvPkg::aluAdd;
      aluSrcA  = 1'b0;
      aluSrcB  = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      wbSrc    = riscvPkg::wbAlu;
      regW     = 1'b0;
      useRs1   = 1'b0;
      useRs2   = 1'b0;
      isBranch = 1'b0;
      branchNe = 1'b0;
      isJump   = 1'b0;
      isHalt   = 1'b0;
      case (opcode)
         `RV_OP_OP: begin
            aluOp  = fnOp;
            regW   = 1'b1;
            useRs1 = 1'b1;
            useRs2 = 1'b1;
         end
         `RV_OP_OPIMM: begin
            imm     = {{20{instr[31]}}, instr[31:20]};
            aluOp   = fnOp;
            aluSrcB = 1'b1;
            regW    = 1'b1;
            useRs1  = 1'b1;
         end
         `RV_OP_LUI: begin
            imm     = {instr[31:12], 12'b0};
            aluOp   = riscvPkg::aluPassB;
            aluSrcB = 1'b1;
            regW    = 1'b1;
         end
         `RV_OP_LOAD: begin
            if (funct3 == 3'b010) begin  // lw only
               imm     = {{20{instr[31]}}, instr[31:20]};
               aluSrcB = 1'b1;
               memRead = 1'b1;
               wbSrc   = riscvPkg::wbMem;
               regW    = 1'b1;
               useRs1  = 1'b1;
            end
         end
         `RV_OP_STORE: begin
            if (funct3 == 3'b010) begin
               imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
               aluSrcB  = 1'b1;
               memWrite = 1'b1;
               useRs1   = 1'b1;
               useRs2   = 1'b1;
            end
         end
         `RV_OP_BRANCH: begin
            if (funct3[2:1] == 2'b00) begin  // beq, bne
               imm      = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
               aluSrcA  = 1'b1;
               aluSrcB  = 1'b1;
               isBranch = 1'b1;
               branchNe = funct3[0];
               useRs1   = 1'b1;
               useRs2   = 1'b1;
            end
         end
         `RV_OP_JAL: begin
            imm     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            aluSrcA = 1'b1;
            aluSrcB = 1'b1;
            wbSrc   = riscvPkg::wbPc4;  // link
            regW    = 1'b1;
            isJump  = 1'b1;
         end
         `RV_OP_SYSTEM: isHalt = (instr == `RV_EBREAK);
         default: ;  // anything else runs as a nop
      endcase
   end

   always_comb begin
      assert (!(memRead && memWrite))
         else $error("pipeCtrl: load and store decoded together, instr %h", instr);
   end

endmodule

// ==== pipeReg.sv ====
module pipeReg #(
   parameter type payloadT = logic
) (
   input  logic    CLK,
   input  logic    RSTn,
   input  logic    stall,
   input  logic    flush,
   input  payloadT d,
   output payloadT q
);

   // all-zero payload is a bubble
   always_ff @(posedge CLK) begin
      if (RSTn || flush) begin
         q <= '0;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

// ==== hazardUnit.sv ====
module hazardUnit (
   input  logic [4:0] idRs1,
   input  logic [4:0] idRs2,
   input  logic       exMemRead,
   input  logic [4:0] exRd,
   input  logic       exRedirect,
   output logic       stallFront,
   output logic       flushIfId,
   output logic       flushIdEx
);
   logic loadUse;

   // load in EX feeding the instruction in ID
   assign loadUse = exMemRead && (exRd != 5'd0)
                    && ((exRd == idRs1) || (exRd == idRs2));

   assign stallFront = loadUse;
   assign flushIfId  = exRedirect;
   assign flushIdEx  = exRedirect || loadUse;  // bubble into EX

   // a load and a taken jump can never sit in EX together
   always_comb begin
      assert (!(stallFront && exRedirect))
         else $error("hazardUnit: stall raised during redirect, exRd %0d", exRd);
   end

endmodule

// ==== forwardUnit.sv ====
module forwardUnit (
   input  logic [4:0]       exRs1,
   input  logic [4:0]       exRs2,
   input  logic [4:0]       memRd,
   input  logic             memRegWrite,
   input  logic [4:0]       wbRd,
   input  logic             wbRegWrite,
   output riscvPkg::fwdSelT fwdA,
   output riscvPkg::fwdSelT fwdB
);
   logic memHitA;
   logic memHitB;
   logic wbHitA;
   logic wbHitB;

   assign memHitA = memRegWrite && (memRd != 5'd0) && (memRd == exRs1);
   assign memHitB = memRegWrite && (memRd != 5'd0) && (memRd == exRs2);
   assign wbHitA  = wbRegWrite && (wbRd != 5'd0) && (wbRd == exRs1);
   assign wbHitB  = wbRegWrite && (wbRd != 5'd0) && (wbRd == exRs2);

   // younger result wins
   assign fwdA = memHitA ? riscvPkg::fwdMem : (wbHitA ? riscvPkg::fwdWb : riscvPkg::fwdReg);
   assign fwdB = memHitB ? riscvPkg::fwdMem : (wbHitB ? riscvPkg::fwdWb : riscvPkg::fwdReg);

   always_comb begin
      assert (!((fwdA != riscvPkg::fwdReg && exRs1 == 5'd0)
                || (fwdB != riscvPkg::fwdReg && exRs2 == 5'd0)))
         else $error("forwardUnit: forward selected for x0");
   end

endmodule

// ==== alu.sv ====
`include "riscv_consts.svh"

module alu (
   input  logic [`RV_XLEN-1:0] a,
   input  logic [`RV_XLEN-1:0] b,
   input  riscvPkg::aluOpT     op,
   output logic [`RV_XLEN-1:0] y,
   input  logic [`RV_XLEN-1:0] cmpA,
   input  logic [`RV_XLEN-1:0] cmpB,
   output logic                eq
);
   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb begin
      case (op)
         riscvPkg::aluAdd:   y = a + b;
         riscvPkg::aluSub:   y = a - b;
         riscvPkg::aluAnd:   y = a & b;
         riscvPkg::aluOr:    y = a | b;
         riscvPkg::aluXor:   y = a ^ b;
         riscvPkg::aluSlt:   y = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         riscvPkg::aluSll:   y = a << shamt;
         riscvPkg::aluSrl:   y = a >> shamt;  // logical
         riscvPkg::aluPassB: y = b;
         default:            y = a + b;
      endcase
   end

   // branch compare on the forwarded register values, not the alu operands
   assign eq = (cmpA == cmpB);

endmodule

// ==== riscvTop.sv ====
`include "riscv_consts.svh"

module riscvTop (
   input  logic                CLK,
   input  logic                RSTn,
   output logic                I_MEM_CSN,
   input  logic [`RV_XLEN-1:0] I_MEM_DI,
   output logic [`RV_AW-1:0]   I_MEM_ADDR,  // byte address
   output logic                D_MEM_CSN,
   input  logic [`RV_XLEN-1:0] D_MEM_DI,
   output logic [`RV_XLEN-1:0] D_MEM_DOUT,
   output logic [`RV_AW-1:0]   D_MEM_ADDR,  // word address
   output logic                D_MEM_WEN,
   output logic [3:0]          D_MEM_BE,
   output logic                RF_WE,
   output logic [4:0]          RF_RA1,
   output logic [4:0]          RF_RA2,
   output logic [4:0]          RF_WA1,
   input  logic [`RV_XLEN-1:0] RF_RD1,
   input  logic [`RV_XLEN-1:0] RF_RD2,
   output logic [`RV_XLEN-1:0] RF_WD,
   output logic                HALT,
   output logic [31:0]         NUM_INST,
   output logic [`RV_XLEN-1:0] OUTPUT_PORT
);
   logic [`RV_XLEN-1:0] pc;
   logic [`RV_XLEN-1:0] ifIdInstr;
   logic [`RV_XLEN-1:0] ifIdPc;
   logic                ifIdValid;
   logic                stallFront;
   logic                flushIfId;
   logic                flushIdEx;
   logic                exRedirect;
   logic                haltFlag;
   logic                wbHalt;
   logic                memStore;
   logic                eq;
   logic [4:0]          idRd;
   logic [`RV_XLEN-1:0] idImm;
   logic                idAluSrcA;
   logic                idAluSrcB;
   logic                idMemRead;
   logic                idMemWrite;
   logic                idRegWrite;
   logic                idIsBranch;
   logic                idBranchNe;
   logic                idIsJump;
   logic                idIsHalt;
   riscvPkg::aluOpT     idAluOp;
   riscvPkg::wbSrcT     idWbSrc;
   riscvPkg::fwdSelT    fwdA;
   riscvPkg::fwdSelT    fwdB;
   logic [`RV_XLEN-1:0] regA;
   logic [`RV_XLEN-1:0] regB;
   logic [`RV_XLEN-1:0] aluA;
   logic [`RV_XLEN-1:0] aluB;
   logic [`RV_XLEN-1:0] aluY;
   logic [`RV_XLEN-1:0] brTarget;
   logic [`RV_XLEN-1:0] memResult;
   riscvPkg::idExT      idExD;
   riscvPkg::idExT      idExQ;
   riscvPkg::exMemT     exMemD;
   riscvPkg::exMemT     exMemQ;
   riscvPkg::memWbT     memWbD;
   riscvPkg::memWbT     memWbQ;

   assign I_MEM_CSN  = RSTn;
   assign D_MEM_CSN  = RSTn;
   assign I_MEM_ADDR = pc[`RV_AW-1:0];

   // fetch
   always_ff @(posedge CLK) begin
      if (RSTn) begin
         pc <= `RV_RESET_PC;
      end else if (!haltFlag) begin
         if (exRedirect) pc <= brTarget;
         else if (!stallFront) pc <= pc + 32'd4;
      end
   end

   always_ff @(posedge CLK) begin
      if (RSTn || (flushIfId && !haltFlag)) begin
         ifIdInstr <= `RV_NOP;
         ifIdValid <= 1'b0;
      end else if (!stallFront && !haltFlag) begin
         ifIdInstr <= I_MEM_DI;
         ifIdValid <= 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (!stallFront && !haltFlag) ifIdPc <= pc;  // payload, no reset
   end

   // decode
   pipeCtrl ctrl (
      .instr(ifIdInstr), .rs1(RF_RA1), .rs2(RF_RA2), .rd(idRd), .imm(idImm),
      .aluOp(idAluOp), .aluSrcA(idAluSrcA), .aluSrcB(idAluSrcB),
      .memRead(idMemRead), .memWrite(idMemWrite), .wbSrc(idWbSrc),
      .regWrite(idRegWrite), .isBranch(idIsBranch), .branchNe(idBranchNe),
      .isJump(idIsJump), .isHalt(idIsHalt)
   );

   assign idExD = '{valid: ifIdValid, pc: ifIdPc, pcPlus4: ifIdPc + 32'd4,
                    rs1: RF_RA1, rs2: RF_RA2, rd: idRd, rd1: RF_RD1, rd2: RF_RD2,
                    imm: idImm, aluOp: idAluOp, aluSrcA: idAluSrcA, aluSrcB: idAluSrcB,
                    memRead: idMemRead, memWrite: idMemWrite, wbSrc: idWbSrc,
                    regWrite: idRegWrite, isBranch: idIsBranch, branchNe: idBranchNe,
                    isJump: idIsJump, isHalt: idIsHalt};

   hazardUnit hazard (
      .idRs1(RF_RA1), .idRs2(RF_RA2), .exMemRead(idExQ.memRead), .exRd(idExQ.rd),
      .exRedirect(exRedirect), .stallFront(stallFront), .flushIfId(flushIfId),
      .flushIdEx(flushIdEx)
   );

   pipeReg #(.payloadT(riscvPkg::idExT)) idExReg (
      .CLK(CLK), .RSTn(RSTn), .stall(haltFlag), .flush(flushIdEx && !haltFlag),
      .d(idExD), .q(idExQ)
   );

   // execute
   forwardUnit fwd (
      .exRs1(idExQ.rs1), .exRs2(idExQ.rs2), .memRd(exMemQ.rd),
      .memRegWrite(exMemQ.regWrite), .wbRd(memWbQ.rd), .wbRegWrite(memWbQ.regWrite),
      .fwdA(fwdA), .fwdB(fwdB)
   );

   assign regA = (fwdA == riscvPkg::fwdMem) ? memResult :
                 (fwdA == riscvPkg::fwdWb)  ? RF_WD : idExQ.rd1;
   assign regB = (fwdB == riscvPkg::fwdMem) ? memResult :
                 (fwdB == riscvPkg::fwdWb)  ? RF_WD : idExQ.rd2;
   assign aluA = idExQ.aluSrcA ? idExQ.pc : regA;
   assign aluB = idExQ.aluSrcB ? idExQ.imm : regB;

   alu exAlu (
      .a(aluA), .b(aluB), .op(idExQ.aluOp), .y(aluY),
      .cmpA(regA), .cmpB(regB), .eq(eq)
   );

   assign brTarget   = idExQ.pc + idExQ.imm;
   assign exRedirect = idExQ.valid
                       && (idExQ.isJump || (idExQ.isBranch && (eq != idExQ.branchNe)));

   assign exMemD = '{valid: idExQ.valid, aluOut: aluY, storeData: regB,
                     pcPlus4: idExQ.pcPlus4, rd: idExQ.rd, memRead: idExQ.memRead,
                     memWrite: idExQ.memWrite, wbSrc: idExQ.wbSrc,
                     regWrite: idExQ.regWrite, isHalt: idExQ.isHalt};

   pipeReg #(.payloadT(riscvPkg::exMemT)) exMemReg (
      .CLK(CLK), .RSTn(RSTn), .stall(haltFlag), .flush(1'b0), .d(exMemD), .q(exMemQ)
   );

   // nothing behind an ebreak in WB may store
   assign memStore   = exMemQ.valid && exMemQ.memWrite && !wbHalt && !haltFlag;
   assign D_MEM_ADDR = exMemQ.aluOut[`RV_AW+1:2];
   assign D_MEM_DOUT = exMemQ.storeData;
   assign D_MEM_WEN  = ~memStore;
   assign D_MEM_BE   = memStore ? 4'b1111 : 4'b0000;

   assign memResult = (exMemQ.wbSrc == riscvPkg::wbMem) ? D_MEM_DI :
                      (exMemQ.wbSrc == riscvPkg::wbPc4) ? exMemQ.pcPlus4 : exMemQ.aluOut;

   assign memWbD = '{valid: exMemQ.valid, aluOut: exMemQ.aluOut, loadData: D_MEM_DI,
                     pcPlus4: exMemQ.pcPlus4, rd: exMemQ.rd, wbSrc: exMemQ.wbSrc,
                     regWrite: exMemQ.regWrite, isHalt: exMemQ.isHalt};

   pipeReg #(.payloadT(riscvPkg::memWbT)) memWbReg (
      .CLK(CLK), .RSTn(RSTn), .stall(haltFlag), .flush(1'b0), .d(memWbD), .q(memWbQ)
   );

   // write back
   assign RF_WD = (memWbQ.wbSrc == riscvPkg::wbMem) ? memWbQ.loadData :
                  (memWbQ.wbSrc == riscvPkg::wbPc4) ? memWbQ.pcPlus4 : memWbQ.aluOut;
   assign RF_WA1      = memWbQ.rd;
   assign RF_WE       = memWbQ.regWrite && !haltFlag;
   assign OUTPUT_PORT = RF_WD;
   assign wbHalt      = memWbQ.valid && memWbQ.isHalt;
   assign HALT        = haltFlag;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         haltFlag <= 1'b0;
         NUM_INST <= '0;
      end else if (!haltFlag) begin
         if (memWbQ.valid) NUM_INST <= NUM_INST + 32'd1;  // ebreak counts too
         if (wbHalt) haltFlag <= 1'b1;
      end
   end

   assert property (@(posedge CLK) disable iff (RSTn) !D_MEM_WEN |-> !$isunknown(D_MEM_ADDR))
      else $error("riscvTop: store to unknown address at pc stage %h", pc);

endmodule

// ==== tb_riscvTop.sv ====
`include "riscv_consts.svh"

module tb_riscvTop;
   logic                CLK;
   logic                RSTn = 1'b1;
   logic                I_MEM_CSN;
   logic [`RV_XLEN-1:0] I_MEM_DI;
   logic [`RV_AW-1:0]   I_MEM_ADDR;
   logic                D_MEM_CSN;
   logic [`RV_XLEN-1:0] D_MEM_DI;
   logic [`RV_XLEN-1:0] D_MEM_DOUT;
   logic [`RV_AW-1:0]   D_MEM_ADDR;
   logic                D_MEM_WEN;
   logic [3:0]          D_MEM_BE;
   logic                RF_WE;
   logic [4:0]          RF_RA1;
   logic [4:0]          RF_RA2;
   logic [4:0]          RF_WA1;
   logic [`RV_XLEN-1:0] RF_RD1;
   logic [`RV_XLEN-1:0] RF_RD2;
   logic [`RV_XLEN-1:0] RF_WD;
   logic                HALT;
   logic [31:0]         NUM_INST;
   logic [`RV_XLEN-1:0] OUTPUT_PORT;

   logic [31:0] imem [0:1023];
   logic [31:0] dmem [0:1023];
   logic [31:0] regs [0:31];
   logic [4:0]  expRd [$];  // register-write trace, in program order
   logic [31:0] expVal [$];
   logic [31:0] memAddr [$];
   logic [31:0] memVal [$];
   int          expCount;
   int          progWords;
   int          wIdx;
   logic        loaded;

   riscvTop uut (.*);

   initial begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   // memories and register file read combinationally
   assign I_MEM_DI = imem[I_MEM_ADDR[11:2]];
   assign D_MEM_DI = dmem[D_MEM_ADDR[9:0]];
   assign RF_RD1 = (RF_RA1 == 5'd0) ? '0 :
                   (RF_WE && RF_WA1 == RF_RA1) ? RF_WD : regs[RF_RA1];
   assign RF_RD2 = (RF_RA2 == 5'd0) ? '0 :
                   (RF_WE && RF_WA1 == RF_RA2) ? RF_WD : regs[RF_RA2];

   always @(posedge CLK) begin
      if (!D_MEM_CSN && !D_MEM_WEN) dmem[D_MEM_ADDR[9:0]] <= D_MEM_DOUT;
      if (RF_WE && RF_WA1 != 5'd0) regs[RF_WA1] <= RF_WD;
   end

   task automatic stopFailed();
      $display("** FAIL **");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic valueMismatch(input string sig, input logic [31:0] got,
                                input logic [31:0] expected);
      $display("FAILED at %0t: %s is %h, expected %h", $time, sig, got, expected);
      stopFailed();
   endtask

   // write trace checker
   always @(posedge CLK) begin
      if (RSTn) begin
         assert (!RF_WE) else valueMismatch("RF_WE", RF_WE, 0);
         assert (D_MEM_WEN) else valueMismatch("D_MEM_WEN", D_MEM_WEN, 1);
         assert (!HALT) else valueMismatch("HALT", HALT, 0);
         assert (I_MEM_CSN) else valueMismatch("I_MEM_CSN", I_MEM_CSN, 1);
         assert (D_MEM_CSN) else valueMismatch("D_MEM_CSN", D_MEM_CSN, 1);
      end else begin
         assert (!I_MEM_CSN) else valueMismatch("I_MEM_CSN", I_MEM_CSN, 0);
         assert (!D_MEM_CSN) else valueMismatch("D_MEM_CSN", D_MEM_CSN, 0);
         if (!D_MEM_WEN)
            assert (D_MEM_BE == 4'hf) else valueMismatch("D_MEM_BE", D_MEM_BE, 4'hf);
         if (RF_WE) begin
            assert (wIdx < expRd.size())
               else begin
                  $display("unexpected register write to x%0d after the whole trace", RF_WA1);
                  stopFailed();
               end
            assert (RF_WA1 == expRd[wIdx]) else valueMismatch("RF_WA1", RF_WA1, expRd[wIdx]);
            assert (RF_WD == expVal[wIdx]) else valueMismatch("RF_WD", RF_WD, expVal[wIdx]);
            assert (OUTPUT_PORT == RF_WD) else valueMismatch("OUTPUT_PORT", OUTPUT_PORT, RF_WD);
            wIdx <= wIdx + 1;
         end
      end
   end

   initial begin
      int        fd;
      int        n;
      int        rd;
      logic [7:0]  tag;
      logic [31:0] addr;
      logic [31:0] word;
      string     line;
      loaded    = 1'b0;
      wIdx      = 0;
      expCount  = 0;
      progWords = 0;
      for (int i = 0; i < 1024; i++) begin
         imem[i] = {2'b00, i[9:0], 20'h00013};  // addi x0, x0, index
         dmem[i] = 32'hd5a0_0000 | i;
      end
      for (int i = 0; i < 32; i++) regs[i] = '0;
      fd = $fopen("riscv_stimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open riscv_stimulus.txt");
         stopFailed();
      end
      while ($fscanf(fd, "%s", tag) == 1) begin
         if (tag == "I") begin
            n = $fscanf(fd, "%h %h", addr, word);
            imem[addr[11:2]] = word;
            progWords++;
         end else if (tag == "W") begin
            n = $fscanf(fd, "%d %h", rd, word);
            expRd.push_back(rd[4:0]);
            expVal.push_back(word);
         end else if (tag == "M") begin
            n = $fscanf(fd, "%h %h", addr, word);
            memAddr.push_back(addr);
            memVal.push_back(word);
         end else if (tag == "N") begin
            n = $fscanf(fd, "%d", expCount);
         end else begin
            n = $fgets(line, fd);  // comment line
         end
      end
      $fclose(fd);
      loaded = 1'b1;

      repeat (10) @(posedge CLK);
      RSTn <= 1'b0;
      wait (HALT === 1'b1);
      @(negedge CLK);
      assert (wIdx == expRd.size())
         else begin
            $display("HALT rose after %0d of %0d expected writes", wIdx, expRd.size());
            stopFailed();
         end
      assert (NUM_INST == expCount) else valueMismatch("NUM_INST", NUM_INST, expCount);
      foreach (memAddr[i])
         assert (dmem[memAddr[i][11:2]] == memVal[i])
            else valueMismatch($sformatf("dmem[%h]", memAddr[i]), dmem[memAddr[i][11:2]],
                               memVal[i]);
      $display("** PASS **");
      $finish;
   end

   // watchdog limit of 20 cycles per program word on top of reset
   initial begin
      int cycles;
      wait (loaded);
      cycles = 10 + 20 * progWords;
      repeat (cycles) @(posedge CLK);
      $display("timeout: HALT did not rise within %0d cycles", cycles);
      stopFailed();
   end

endmodule

// ==== riscv_stimulus.txt ====
# I byte-address word: program | W rd value: expected write, in order
# M byte-address value: data memory after HALT | N count: NUM_INST at HALT
I 00000000 00500093
I 00000004 FFD00113
I 00000008 002081B3
I 0000000C 40208233
I 00000010 0041F2B3
I 00000014 0041E333
I 00000018 001343B3
I 0000001C 00112433
I 00000020 008094B3
I 00000024 00115533
I 00000028 0063F593
I 0000002C 1005E613
I 00000030 FFF64693
I 00000034 0006A713
I 00000038 123457B7
I 0000003C 67878793
I 00000040 00F02823
I 00000044 01002803
I 00000048 001808B3
I 0000004C 00208463
I 00000050 00100913
I 00000054 00209663
I 00000058 7FF00993
I 0000005C 12300993
I 00000060 00028663
I 00000064 00900A13
I 00000068 00A00A13
I 0000006C 00C00AEF
I 00000070 00100B13
I 00000074 00200B13
I 00000078 00319463
I 0000007C 012A8BB3
I 00000080 00100073
W 1 00000005
W 2 FFFFFFFD
W 3 00000002
W 4 00000008
W 5 00000000
W 6 0000000A
W 7 0000000F
W 8 00000001
W 9 0000000A
W 10 07FFFFFF
W 11 00000006
W 12 00000106
W 13 FFFFFEF9
W 14 00000001
W 15 12345000
W 15 12345678
W 16 12345678
W 17 1234567D
W 18 00000001
W 21 00000070
W 23 00000071
M 00000010 12345678
N 27

// ==== src.f ====
+incdir+.
riscvPkg.sv
pipeCtrl.sv
pipeReg.sv
hazardUnit.sv
forwardUnit.sv
alu.sv
riscvTop.sv
tb_riscvTop.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_riscvTop -o simv
./obj_dir/simv | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi
